// File: cbm2_loader.f
hdl/cbm2_loader_pkg.sv
hdl/loader_ifs.sv
hdl/ioctl_decode.sv
hdl/prg_injector.sv
hdl/mem_write_port.sv
hdl/sid_filter_loader.sv
hdl/cbm2_loader.sv
+incdir+tb
tb/tb_cbm2_loader.sv

// File: hdl/cbm2_loader.sv
// Loader top level
//   Download decode, PRG injector, memory write port
//   and SID filter loader wired together

`timescale 1ns/1ps

module cbm2_loader
	import cbm2_loader_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  logic                   ioctl_download_i,
	input  logic [7:0]             ioctl_index_i,
	input  logic                   ioctl_wr_i,
	input  logic [LOAD_ADDR_W-1:0] ioctl_addr_i,
	input  logic [LOAD_DATA_W-1:0] ioctl_data_i,
	output logic                   ioctl_wait_o,
	input  logic                   model_i,
	input  logic                   io_cycle_i,
	output logic                   mem_ce_o,
	output logic                   mem_we_o,
	output logic [LOAD_ADDR_W-1:0] mem_addr_o,
	output logic [LOAD_DATA_W-1:0] mem_data_o,
	output logic                   rom_wr_o,
	output logic [5:0]             rom_id_o,
	output logic [ROM_ADDR_W-1:0]  rom_addr_o,
	output logic [LOAD_DATA_W-1:0] rom_data_o,
	output logic [SID_ADDR_W-1:0]  sid_ld_addr_o,
	output logic [SID_DATA_W-1:0]  sid_ld_data_o,
	output logic                   sid_ld_wr_o
);

	ioctl_stream_if stream ();
	mem_req_if      mem ();

	logic prg_end;

	// ========================================
	// Download front end
	// ========================================
	ioctl_decode u_ioctl_decode (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.stream           (stream.source),
		.prg_end_o        (prg_end),
		.rom_wr_o         (rom_wr_o),
		.rom_id_o         (rom_id_o),
		.rom_addr_o       (rom_addr_o),
		.rom_data_o       (rom_data_o)
	);

	// ========================================
	// Consumers
	// ========================================
	prg_injector u_prg_injector (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.model_i      (model_i),
		.stream       (stream.sink),
		.prg_end_i    (prg_end),
		.mem          (mem.requester),
		.ioctl_wait_o (ioctl_wait_o)
	);

	mem_write_port u_mem_write_port (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.io_cycle_i (io_cycle_i),
		.mem        (mem.port),
		.mem_ce_o   (mem_ce_o),
		.mem_we_o   (mem_we_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o)
	);

	sid_filter_loader u_sid_filter_loader (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.stream        (stream.sink),
		.sid_ld_addr_o (sid_ld_addr_o),
		.sid_ld_data_o (sid_ld_data_o),
		.sid_ld_wr_o   (sid_ld_wr_o)
	);

endmodule

// File: hdl/cbm2_loader_pkg.sv
// Shared definitions for the download loader
//   Widths of download, ROM and SID filter buses
//   Download index boundaries
//   BASIC pointer block address
//   Download kind and injector state enums

package cbm2_loader_pkg;

	// ========================================
	// Bus widths
	// ========================================
	localparam int LOAD_ADDR_W = 25;
	localparam int LOAD_DATA_W = 8;
	localparam int ROM_ADDR_W  = 14;
	localparam int SID_ADDR_W  = 12;
	localparam int SID_DATA_W  = 16;

	// Filter table size in bytes
	localparam int SID_BYTE_LIMIT = 6144;

	// ========================================
	// Download index map, low six bits
	// ========================================
	localparam int IDX_ROM_FIRST = 2;
	localparam int IDX_CHR_FIRST = 11;
	localparam int IDX_PRG       = 14;
	localparam int IDX_FLT       = 15;

	// TXTTAB/TXTEND in bank 15, four bytes
	localparam logic [LOAD_ADDR_W-1:0] ptr_base = 25'h0F002D;

	typedef enum logic [2:0] {
		kind_none,
		kind_rom,
		kind_chr,
		kind_prg,
		kind_flt
	} download_kind_t;

	typedef enum logic [1:0] {
		st_idle,
		st_header,
		st_body,
		st_pointers
	} inject_state_t;

endpackage

// File: hdl/ioctl_decode.sv
// Host download front end
//   Index to download kind mapping
//   Registered byte stream to the consumers
//   ROM and character set write forwarding
//   End of PRG download strobe

`timescale 1ns/1ps

module ioctl_decode
	import cbm2_loader_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  logic                   ioctl_download_i,
	input  logic [7:0]             ioctl_index_i,
	input  logic                   ioctl_wr_i,
	input  logic [LOAD_ADDR_W-1:0] ioctl_addr_i,
	input  logic [LOAD_DATA_W-1:0] ioctl_data_i,
	ioctl_stream_if.source         stream,
	output logic                   prg_end_o,
	output logic                   rom_wr_o,
	output logic [5:0]             rom_id_o,
	output logic [ROM_ADDR_W-1:0]  rom_addr_o,
	output logic [LOAD_DATA_W-1:0] rom_data_o
);

	logic [5:0]     idx;
	download_kind_t kind;
	logic           rom_hit;
	logic           dl_q;
	logic           prg_dl;

	assign idx = ioctl_index_i[5:0];

	always_comb begin
		if (idx >= IDX_ROM_FIRST && idx < IDX_CHR_FIRST)
			kind = kind_rom;
		else if (idx >= IDX_CHR_FIRST && idx < IDX_PRG)
			kind = kind_chr;
		else if (idx == IDX_PRG)
			kind = kind_prg;
		else if (idx == IDX_FLT)
			kind = kind_flt;
		else
			kind = kind_none;
	end

	// Only the first 16K of a ROM image is kept
	assign rom_hit = (kind == kind_rom || kind == kind_chr) &&
	                 (ioctl_addr_i[LOAD_ADDR_W-1:ROM_ADDR_W] == '0);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			stream.wr <= 1'b0;
			rom_wr_o  <= 1'b0;
			prg_end_o <= 1'b0;
			dl_q      <= 1'b0;
			prg_dl    <= 1'b0;
		end else begin
			stream.wr <= ioctl_wr_i;
			rom_wr_o  <= ioctl_wr_i && ioctl_download_i && rom_hit;
			dl_q      <= ioctl_download_i;
			prg_end_o <= 1'b0;

			// Remember the kind while the download runs
			if (ioctl_download_i) begin
				prg_dl <= (kind == kind_prg);
			end else if (dl_q) begin
				prg_end_o <= prg_dl;
				prg_dl    <= 1'b0;
			end
		end
	end

	// Payload follows the strobe
	always_ff @(posedge clk_sys) begin
		stream.addr <= ioctl_addr_i;
		stream.data <= ioctl_data_i;
		stream.kind <= kind;
		rom_id_o    <= idx;
		rom_addr_o  <= ioctl_addr_i[ROM_ADDR_W-1:0];
		rom_data_o  <= ioctl_data_i;
	end

endmodule

// File: hdl/loader_ifs.sv
// Internal interfaces of the loader
//   ioctl_stream_if  registered download byte stream
//   mem_req_if       single write request with acknowledge

`timescale 1ns/1ps

// Byte stream, wr is a one-cycle strobe
interface ioctl_stream_if
	import cbm2_loader_pkg::*;
();

	logic                   wr;
	logic [LOAD_ADDR_W-1:0] addr;
	logic [LOAD_DATA_W-1:0] data;
	download_kind_t         kind;

	modport source (output wr, output addr, output data, output kind);
	modport sink   (input wr, input addr, input data, input kind);

endinterface

// Request held with addr and data until ack
interface mem_req_if
	import cbm2_loader_pkg::*;
();

	logic                   req;
	logic [LOAD_ADDR_W-1:0] addr;
	logic [LOAD_DATA_W-1:0] data;
	logic                   ack;

	modport requester (output req, output addr, output data, input ack);
	modport port      (input req, input addr, input data, output ack);

endinterface

// File: hdl/mem_write_port.sv
// Memory write port for the loader
//   io_cycle falling edge detection
//   One write per request in the free half of the memory cycle
//   Acknowledge to the requester

`timescale 1ns/1ps

module mem_write_port
	import cbm2_loader_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  logic                   io_cycle_i,
	mem_req_if.port                mem,
	output logic                   mem_ce_o,
	output logic                   mem_we_o,
	output logic [LOAD_ADDR_W-1:0] mem_addr_o,
	output logic [LOAD_DATA_W-1:0] mem_data_o
);

	logic io_q;
	logic io_fall;
	logic io_rise;

	assign io_fall = !io_cycle_i && io_q;
	assign io_rise = io_cycle_i && !io_q;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			io_q     <= 1'b0;
			mem_ce_o <= 1'b0;
			mem_we_o <= 1'b0;
			mem.ack  <= 1'b0;
		end else begin
			io_q    <= io_cycle_i;
			mem.ack <= 1'b0;

			if (io_fall && mem.req) begin
				mem_ce_o <= 1'b1;
				mem_we_o <= 1'b1;
				mem.ack  <= 1'b1;
			end else if (io_rise) begin
				// Bus goes back to the CPU side
				mem_ce_o <= 1'b0;
				mem_we_o <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (io_fall && mem.req) begin
			mem_addr_o <= mem.addr;
			mem_data_o <= mem.data;
		end
	end

endmodule

// File: hdl/prg_injector.sv
// Program file injection into main RAM
//   Header parsing for the load address
//   Body byte write requests, one at a time
//   BASIC start and end pointers after the download
//   Host wait while writes are outstanding

`timescale 1ns/1ps

module prg_injector
	import cbm2_loader_pkg::*;
(
	input  logic         clk_sys,
	input  logic         RESET,
	input  logic         model_i,
	ioctl_stream_if.sink stream,
	input  logic         prg_end_i,
	mem_req_if.requester mem,
	output logic         ioctl_wait_o
);

	inject_state_t           state;
	logic                    end_pend;
	logic [1:0]              ptr_idx;
	logic [LOAD_ADDR_W-17:0] load_bank;
	logic [15:0]             load_off;
	logic [15:0]             inj_start;
	logic                    prg_byte;

	assign prg_byte = stream.wr && (stream.kind == kind_prg);

	// Host held off until the last pointer write is taken
	assign ioctl_wait_o = mem.req || end_pend || (state == st_pointers);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state    <= st_idle;
			mem.req  <= 1'b0;
			end_pend <= 1'b0;
			ptr_idx  <= '0;
		end else begin
			if (mem.ack)
				mem.req <= 1'b0;
			if (prg_end_i)
				end_pend <= 1'b1;

			// Pointers start once the last body write is done
			if (state != st_pointers && end_pend && !mem.req) begin
				state    <= st_pointers;
				end_pend <= 1'b0;
				ptr_idx  <= '0;
			end else begin
				case (state)
					st_idle: begin
						if (prg_byte && stream.addr == '0) begin
							load_bank      <= model_i ? 9'd1 : 9'd0;
							load_off[7:0]  <= stream.data;
							inj_start[7:0] <= stream.data;
							state          <= st_header;
						end
					end

					st_header: begin
						if (prg_byte && stream.addr == LOAD_ADDR_W'(1)) begin
							load_off[15:8]  <= stream.data;
							inj_start[15:8] <= stream.data;
							state           <= st_body;
						end
					end

					st_body: begin
						if (prg_byte && stream.addr > LOAD_ADDR_W'(1)) begin
							mem.req  <= 1'b1;
							mem.addr <= {load_bank, load_off};
							mem.data <= stream.data;
							// Ends up as start plus body length
							load_off <= load_off + 16'd1;
						end
					end

					st_pointers: begin
						if (mem.ack) begin
							if (ptr_idx == 2'd3)
								state <= st_idle;
							else
								ptr_idx <= ptr_idx + 2'd1;
						end else if (!mem.req) begin
							mem.req  <= 1'b1;
							mem.addr <= ptr_base + LOAD_ADDR_W'(ptr_idx);
							case (ptr_idx)
								2'd0:    mem.data <= inj_start[7:0];
								2'd1:    mem.data <= inj_start[15:8];
								2'd2:    mem.data <= load_off[7:0];
								default: mem.data <= load_off[15:8];
							endcase
						end
					end

					default: state <= st_idle;
				endcase
			end
		end
	end

endmodule

// File: hdl/sid_filter_loader.sv
// SID filter table loader
//   Pairs filter bytes into 16-bit words
//   One write strobe per completed word

`timescale 1ns/1ps

module sid_filter_loader
	import cbm2_loader_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  RESET,
	ioctl_stream_if.sink          stream,
	output logic [SID_ADDR_W-1:0] sid_ld_addr_o,
	output logic [SID_DATA_W-1:0] sid_ld_data_o,
	output logic                  sid_ld_wr_o
);

	logic flt_byte;

	assign flt_byte = stream.wr && (stream.kind == kind_flt) &&
	                  (stream.addr < LOAD_ADDR_W'(SID_BYTE_LIMIT));

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			sid_ld_wr_o <= 1'b0;
		end else begin
			sid_ld_wr_o <= 1'b0;
			if (flt_byte) begin
				if (stream.addr[0]) begin
					// Odd byte completes the word
					sid_ld_data_o[15:8] <= stream.data;
					sid_ld_addr_o       <= stream.addr[SID_ADDR_W:1];
					sid_ld_wr_o         <= 1'b1;
				end else begin
					sid_ld_data_o[7:0] <= stream.data;
				end
			end
		end
	end

endmodule

// File: tb/tb_loader_checks.svh
// Testbench helpers for the loader
//   Value compare with error report
//   LCG step for random io_cycle timing
//   Expected ROM, memory and SID event queues from the session table

`ifndef TB_LOADER_CHECKS_SVH
`define TB_LOADER_CHECKS_SVH

task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                           input string msg);
	if (actual !== expected) begin
		$display("ERR %0t: %s got %h expected %h", $time, msg, actual, expected);
		$display("Test failures found");
		$fatal(1);
	end
endtask

function automatic int unsigned lcg_next(input int unsigned s);
	return s * 32'd1103515245 + 32'd12345;
endfunction

// Walks every session and applies the loader rules byte by byte
task automatic build_expected();
	int          pos;
	int          a;
	logic [5:0]  idx;
	logic [7:0]  d;
	logic [7:0]  lo;
	logic [15:0] start;
	logic [15:0] fin;
	logic [24:0] ma;
	pos = 0;
	lo  = 8'h00;
	for (int s = 0; s < NS; s++) begin
		idx   = sess_idx[s][5:0];
		start = 16'h0000;
		for (int i = 0; i < sess_len[s]; i++) begin
			a = sess_addr[s] + i;
			d = pool[pos + i];
			if (idx >= 2 && idx <= 13) begin
				if (a < 16384)
					exp_rom.push_back(64'({idx, 14'(a), d}));
			end else if (idx == 14) begin
				if (i == 0)
					start[7:0] = d;
				else if (i == 1)
					start[15:8] = d;
				else begin
					ma = {9'(sess_model[s]), 16'(start + 16'(i - 2))};
					exp_mem.push_back(64'({ma, d}));
				end
			end else if (idx == 15 && a < 6144) begin
				if (a % 2 == 1)
					exp_sid.push_back(64'({12'(a / 2), d, lo}));
				else
					lo = d;
			end
		end
		// Pointer block follows each program
		if (idx == 14) begin
			fin = start + 16'(sess_len[s] - 2);
			exp_mem.push_back(64'({ptr_base, start[7:0]}));
			exp_mem.push_back(64'({ptr_base + 25'd1, start[15:8]}));
			exp_mem.push_back(64'({ptr_base + 25'd2, fin[7:0]}));
			exp_mem.push_back(64'({ptr_base + 25'd3, fin[15:8]}));
		end
		pos += sess_len[s];
	end
endtask

`endif

// File: tb/tb_cbm2_loader.sv
// Testbench for the loader top level
//   Clock, reset and DUT
//   Session table applied by the host driver
//   Random io_cycle timing, event monitors, watchdog

`timescale 1ns/1ps

module tb_cbm2_loader
	import cbm2_loader_pkg::*;
;

	localparam int NS = 9;

	logic        clk_sys;
	logic        RESET;
	logic        ioctl_download_i;
	logic [7:0]  ioctl_index_i;
	logic        ioctl_wr_i;
	logic [24:0] ioctl_addr_i;
	logic [7:0]  ioctl_data_i;
	logic        model_i;
	logic        io_cycle_i;
	logic        ioctl_wait_o;
	logic        mem_ce_o;
	logic        mem_we_o;
	logic [24:0] mem_addr_o;
	logic [7:0]  mem_data_o;
	logic        rom_wr_o;
	logic [5:0]  rom_id_o;
	logic [13:0] rom_addr_o;
	logic [7:0]  rom_data_o;
	logic [11:0] sid_ld_addr_o;
	logic [15:0] sid_ld_data_o;
	logic        sid_ld_wr_o;

	// Session table: index, model, first address, byte count
	logic [7:0]  sess_idx   [NS] = '{8'd3, 8'd12, 8'd3, 8'd0, 8'd63, 8'd14, 8'd14, 8'd15, 8'd15};
	logic        sess_model [NS] = '{0, 0, 0, 0, 0, 0, 1, 0, 0};
	int          sess_addr  [NS] = '{0, 100, 16382, 0, 0, 0, 0, 0, 6144};
	int          sess_len   [NS] = '{6, 4, 4, 3, 3, 8, 10, 10, 2};
	logic [7:0]  pool [64];

	logic [63:0] exp_mem[$], exp_rom[$], exp_sid[$];
	logic [63:0] got_mem[$], got_rom[$], got_sid[$];
	int unsigned seed = 4374;
	int          total_bytes;
	logic        we_q;
	int          io_high_cnt;

	`include "tb_loader_checks.svh"

	cbm2_loader u_cbm2_loader (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// io_cycle toggles with random phase lengths
	initial begin
		int len;
		io_cycle_i = 1'b0;
		forever begin
			seed = lcg_next(seed);
			len  = ((seed >> 16) % 6) + 1;
			repeat (len) @(negedge clk_sys);
			io_cycle_i <= ~io_cycle_i;
		end
	end

	always @(negedge clk_sys) begin
		if (RESET) begin
			we_q        = 1'b0;
			io_high_cnt = 0;
		end else begin
			io_high_cnt = io_cycle_i ? io_high_cnt + 1 : 0;
			if (io_high_cnt >= 2) begin
				check_value(mem_we_o, 0, "mem_we_o high in io_cycle high phase");
				check_value(mem_ce_o, 0, "mem_ce_o high in io_cycle high phase");
			end
			if (mem_we_o && !we_q) begin
				check_value(mem_ce_o, 1, "mem_ce_o at write start");
				got_mem.push_back(64'({mem_addr_o, mem_data_o}));
			end
			if (rom_wr_o)
				got_rom.push_back(64'({rom_id_o, rom_addr_o, rom_data_o}));
			if (sid_ld_wr_o)
				got_sid.push_back(64'({sid_ld_addr_o, sid_ld_data_o}));
			we_q = mem_we_o;
		end
	end

	initial begin
		total_bytes = 0;
		foreach (sess_len[s])
			total_bytes += sess_len[s];
		#((total_bytes * 20 + 1000) * 100);
		$display("Timeout: the run did not finish within the expected time");
		$display("Test failures found");
		$fatal(1);
	end

	task automatic run_session(input int s, input int pos);
		@(negedge clk_sys);
		ioctl_index_i    <= sess_idx[s];
		model_i          <= sess_model[s];
		ioctl_download_i <= 1'b1;
		for (int i = 0; i < sess_len[s]; i++) begin
			@(negedge clk_sys);
			while (ioctl_wait_o)
				@(negedge clk_sys);
			ioctl_wr_i   <= 1'b1;
			ioctl_addr_i <= 25'(sess_addr[s] + i);
			ioctl_data_i <= pool[pos + i];
			@(negedge clk_sys);
			ioctl_wr_i <= 1'b0;
		end
		@(negedge clk_sys);
		ioctl_download_i <= 1'b0;
		repeat (3) @(negedge clk_sys);
		while (ioctl_wait_o)
			@(negedge clk_sys);
		repeat (2) @(negedge clk_sys);
	endtask

	initial begin
		int pos;
		RESET            = 1'b1;
		ioctl_download_i = 1'b0;
		ioctl_index_i    = 8'd0;
		ioctl_wr_i       = 1'b0;
		ioctl_addr_i     = '0;
		ioctl_data_i     = 8'd0;
		model_i          = 1'b0;
		for (int i = 0; i < 64; i++)
			pool[i] = 8'((i * 37 + 11) ^ (i >> 2));
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		RESET <= 1'b0;
		@(negedge clk_sys);
		check_value(ioctl_wait_o, 0, "ioctl_wait_o after reset");
		check_value(mem_ce_o, 0, "mem_ce_o after reset");
		check_value(mem_we_o, 0, "mem_we_o after reset");
		check_value(rom_wr_o, 0, "rom_wr_o after reset");
		check_value(sid_ld_wr_o, 0, "sid_ld_wr_o after reset");

		build_expected();
		pos = 0;
		for (int s = 0; s < NS; s++) begin
			run_session(s, pos);
			pos += sess_len[s];
		end
		repeat (20) @(negedge clk_sys);

		check_value(got_rom.size(), exp_rom.size(), "ROM write count");
		foreach (exp_rom[i])
			check_value(got_rom[i], exp_rom[i], "ROM write id/addr/data");
		check_value(got_mem.size(), exp_mem.size(), "memory write count");
		foreach (exp_mem[i])
			check_value(got_mem[i], exp_mem[i], "memory write addr/data");
		check_value(got_sid.size(), exp_sid.size(), "SID word count");
		foreach (exp_sid[i])
			check_value(got_sid[i], exp_sid[i], "SID word addr/data");

		$display("All tests passed!");
		$finish;
	end

endmodule
